//--- hdl/erx_macros.svh
/* Link receive parameters
   Packet geometry, link id and burst addressing constants */
`ifndef ERX_MACROS_SVH
`define ERX_MACROS_SVH

// Packet width in bits
`define ERX_PW 104

// Bytes on the wire per packet
`define ERX_BYTES 13

// Id of this link, top 12 address bits
`define ERX_ID 12'h800

// Address group reserved for read responses
`define ERX_GROUP_RR 4'hd

// Address step between burst packets
`define ERX_STRIDE 8

`endif

//--- hdl/erx_pkg.sv
/* Link receive types
   Address views, packet layout and packet classification */
package erx_pkg;

  // Field view of a destination address
  typedef struct packed {
    logic [11:0] id;
    logic [3:0]  group;
    logic [15:0] offset;
  } erx_addr_fields_t;

  // Same word, raw or decoded
  typedef union packed {
    logic [31:0]      raw;
    erx_addr_fields_t fields;
  } erx_addr_u;

  // Wire byte 0 lands in srcaddr[31:24]
  typedef struct packed {
    logic [31:0] srcaddr;
    logic [31:0] data;
    erx_addr_u   dstaddr;
    logic [7:0]  ctrl;
  } erx_packet_t;

  typedef enum logic [1:0] {KIND_RDWR, KIND_RR, KIND_TEST} erx_kind_t;

endpackage

//--- hdl/erx_pkt_if.sv
/* Packet link between receive stages
   Valid/ready handshake carrying a packet, burst flag and kind */
interface erx_pkt_if import erx_pkg::*; ();

  logic        valid;
  logic        ready;
  logic        burst;
  erx_kind_t   kind;
  erx_packet_t packet;

  // Producer side
  modport src (output valid, burst, kind, packet, input ready);

  // Consumer side
  modport dst (input valid, burst, kind, packet, output ready);

endinterface

//--- hdl/erx_deframer.sv
/* Link deframer
   Shifts framed bytes into packets and flags burst continuation */
`include "erx_macros.svh"

module erx_deframer import erx_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] rx_byte,
  input  logic       rx_frame,
  input  logic       rx_byte_valid,
  output logic       rx_ready,
  erx_pkt_if.src     out
);

  logic [`ERX_PW-1:0] shift_q;
  logic [3:0]         count_q;
  logic               cont_q;
  logic               valid_q;
  logic               burst_q;
  logic               take;
  logic               last_byte;

  // Sender holds off while a packet is parked
  assign rx_ready  = ~valid_q;
  assign take      = rx_byte_valid & rx_ready;
  assign last_byte = take & (count_q == 4'(`ERX_BYTES - 1));

  // Payload path, byte 0 ends up on top
  always_ff @(posedge clk)
  begin
    if (take)
      shift_q <= {shift_q[`ERX_PW-9:0], rx_byte};
    // Burst flag frozen with the packet
    if (last_byte)
      burst_q <= cont_q;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count_q <= '0;
      valid_q <= 1'b0;
      cont_q  <= 1'b0;
    end
    else
    begin
      // Byte counter wraps at packet end
      if (last_byte)
        count_q <= '0;
      else if (take)
        count_q <= count_q + 4'd1;

      // Packet held until the protocol stage takes it
      if (last_byte)
        valid_q <= 1'b1;
      else if (out.ready)
        valid_q <= 1'b0;

      // Any frame drop breaks the burst chain
      if (~rx_frame)
        cont_q <= 1'b0;
      else if (last_byte)
        cont_q <= 1'b1;
    end
  end

  assign out.valid  = valid_q;
  assign out.burst  = burst_q;
  assign out.packet = erx_packet_t'(shift_q);
  // Not classified yet
  assign out.kind   = KIND_RDWR;

endmodule

//--- hdl/erx_protocol.sv
/* Receive protocol stage
   Burst address generation, read response detection and classification */
`include "erx_macros.svh"

module erx_protocol import erx_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   test_mode,
  erx_pkt_if.dst in,
  erx_pkt_if.src out
);

  erx_addr_u   addr_q;
  erx_addr_u   addr_sel;
  erx_packet_t pkt_next;
  logic        accept;
  logic        read_response;
  logic        valid_q;

  // Room when empty or draining this cycle
  assign in.ready = ~valid_q | out.ready;
  assign accept   = in.valid & in.ready;

  // Burst packets ignore their own address
  assign addr_sel.raw = in.burst ? addr_q.raw + 32'(`ERX_STRIDE) : in.packet.dstaddr.raw;

  // Response check on the selected address
  assign read_response = (addr_sel.fields.id == `ERX_ID) &
                         (addr_sel.fields.group == `ERX_GROUP_RR);

  always_comb
  begin
    pkt_next         = in.packet;
    pkt_next.dstaddr = addr_sel;
  end

  // Address and payload registers
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q     <= addr_sel;
      out.packet <= pkt_next;
      if (read_response)
        out.kind <= KIND_RR;
      else
        out.kind <= test_mode ? KIND_TEST : KIND_RDWR;
    end
  end

  // Test mode swallows read responses
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      valid_q <= 1'b0;
    else if (accept)
      valid_q <= ~(test_mode & read_response);
    else if (out.ready)
      valid_q <= 1'b0;
  end

  assign out.valid = valid_q;
  assign out.burst = 1'b0;

endmodule

//--- hdl/erx_dispatch.sv
/* Packet dispatcher
   Routes classified packets to request, response or test sink */
module erx_dispatch import erx_pkg::*; (
  erx_pkt_if.dst      in,
  output logic        req_valid,
  input  logic        req_ready,
  output erx_packet_t req_packet,
  output logic        rr_valid,
  input  logic        rr_ready,
  output erx_packet_t rr_packet,
  output logic        test_valid,
  output logic [31:0] test_data
);

  // One valid per kind
  assign req_valid  = in.valid & (in.kind == KIND_RDWR);
  assign rr_valid   = in.valid & (in.kind == KIND_RR);
  assign test_valid = in.valid & (in.kind == KIND_TEST);

  // Same payload on both ports, only valid differs
  assign req_packet = in.packet;
  assign rr_packet  = in.packet;

  // Sink folds only the data word
  assign test_data  = in.packet.data;

  // Stall follows the selected port only
  always_comb
  begin
    case (in.kind)
      KIND_RDWR:
        in.ready = req_ready;
      KIND_RR:
        in.ready = rr_ready;
      default:
        // Test sink never stalls
        in.ready = 1'b1;
    endcase
  end

endmodule

//--- hdl/erx_test_sink.sv
/* Test packet sink
   Counts test packets and keeps a rotate-xor data signature */
module erx_test_sink (
  input  logic        clk,
  input  logic        reset,
  input  logic        test_valid,
  input  logic [31:0] test_data,
  output logic [15:0] test_count,
  output logic [31:0] test_signature
);

  logic [31:0] sig_next;

  // Rotate left one bit then fold in data
  assign sig_next = {test_signature[30:0], test_signature[31]} ^ test_data;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      test_count     <= '0;
      test_signature <= '0;
    end
    else if (test_valid)
    begin
      // Count wraps silently
      test_count     <= test_count + 16'd1;
      test_signature <= sig_next;
    end
  end

endmodule

//--- hdl/erx_top.sv
/* Link receive protocol top
   Deframer, protocol stage, dispatcher and test sink */
module erx_top import erx_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        test_mode,
  input  logic [7:0]  rx_byte,
  input  logic        rx_frame,
  input  logic        rx_byte_valid,
  output logic        rx_ready,
  output logic        req_valid,
  input  logic        req_ready,
  output erx_packet_t req_packet,
  output logic        rr_valid,
  input  logic        rr_ready,
  output erx_packet_t rr_packet,
  output logic [15:0] test_count,
  output logic [31:0] test_signature
);

  logic        test_valid;
  logic [31:0] test_data;

  // Deframer to protocol, then protocol to dispatcher
  erx_pkt_if deframe_link ();
  erx_pkt_if class_link ();

  erx_deframer u_deframer (
    .clk           (clk),
    .reset         (reset),
    .rx_byte       (rx_byte),
    .rx_frame      (rx_frame),
    .rx_byte_valid (rx_byte_valid),
    .rx_ready      (rx_ready),
    .out           (deframe_link.src)
  );

  erx_protocol u_protocol (
    .clk       (clk),
    .reset     (reset),
    .test_mode (test_mode),
    .in        (deframe_link.dst),
    .out       (class_link.src)
  );

  erx_dispatch u_dispatch (
    .in         (class_link.dst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_packet (req_packet),
    .rr_valid   (rr_valid),
    .rr_ready   (rr_ready),
    .rr_packet  (rr_packet),
    .test_valid (test_valid),
    .test_data  (test_data)
  );

  erx_test_sink u_test_sink (
    .clk            (clk),
    .reset          (reset),
    .test_valid     (test_valid),
    .test_data      (test_data),
    .test_count     (test_count),
    .test_signature (test_signature)
  );

endmodule

//--- tests/erx_checker.sv
/* Receive link checker
   Rebuilds packets from taken bytes, predicts every output and compares */
`include "erx_macros.svh"

module erx_checker import erx_pkg::*; (
  input logic        clk,
  input logic        reset,
  input logic        test_mode,
  input logic [7:0]  rx_byte,
  input logic        rx_frame,
  input logic        rx_byte_valid,
  input logic        rx_ready,
  input logic        req_valid,
  input logic        req_ready,
  input erx_packet_t req_packet,
  input logic        rr_valid,
  input logic        rr_ready,
  input erx_packet_t rr_packet,
  input logic [15:0] test_count,
  input logic [31:0] test_signature
);
  timeunit 1ns;
  timeprecision 100ps;

  int          value_errors = 0;
  int          other_errors = 0;
  erx_packet_t req_q[$];
  erx_packet_t rr_q[$];
  logic [`ERX_PW-1:0] shift;
  int          nbytes;
  bit          cont;
  bit          parked;
  logic [31:0] prev_addr;
  logic [15:0] exp_count;
  logic [31:0] exp_sig;

  // Model of one packet leaving the deframer
  task automatic predict(input erx_packet_t p, input bit burst);
    logic [31:0] addr;
    bit          is_rr;
    addr = burst ? prev_addr + `ERX_STRIDE : p.dstaddr.raw;
    prev_addr = addr;
    p.dstaddr.raw = addr;
    // id in the top 12 bits, group in the next 4
    is_rr = (addr[31:20] == `ERX_ID) && (addr[19:16] == `ERX_GROUP_RR);
    if (is_rr)
    begin
      if (!test_mode)
        rr_q.push_back(p);
    end
    else if (test_mode)
    begin
      exp_count = exp_count + 1;
      exp_sig = {exp_sig[30:0], exp_sig[31]} ^ p.data;
    end
    else
      req_q.push_back(p);
  endtask

  task automatic compare(input string port, input erx_packet_t got, ref erx_packet_t q[$]);
    erx_packet_t exp;
    if (q.size() == 0)
    begin
      other_errors++;
      $display("Unexpected packet on the %s port at %0t ns", port, $time);
    end
    else
    begin
      exp = q.pop_front();
      if (got !== exp)
      begin
        value_errors++;
        $display("Error at %0t ns: %s packet %h, expected %h", $time, port, got, exp);
      end
    end
  endtask

  // Called by the testbench once the DUT is idle
  task automatic check_idle();
    if (req_q.size() != 0 || rr_q.size() != 0)
    begin
      other_errors++;
      $display("Packets never delivered: %0d request, %0d response", req_q.size(),
               rr_q.size());
      req_q.delete();
      rr_q.delete();
    end
    if (test_count !== exp_count || test_signature !== exp_sig)
    begin
      value_errors++;
      $display("Error at %0t ns: sink count %h signature %h, expected %h %h", $time,
               test_count, test_signature, exp_count, exp_sig);
    end
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      req_q.delete();
      rr_q.delete();
      nbytes = 0;
      cont = 0;
      parked = 0;
      exp_count = '0;
      exp_sig = '0;
      // Reset state seen on the outputs
      if (req_valid || rr_valid || !rx_ready || test_count != 0 || test_signature != 0)
      begin
        value_errors++;
        $display("Error at %0t ns: outputs not in reset state", $time);
      end
    end
    else
    begin
      if (req_valid && rr_valid)
      begin
        other_errors++;
        $display("Both output ports valid at %0t ns", $time);
      end
      if (req_valid && req_ready)
        compare("request", req_packet, req_q);
      if (rr_valid && rr_ready)
        compare("response", rr_packet, rr_q);
      // Deframer holds a packet right after its last byte
      if (parked && rx_ready)
      begin
        value_errors++;
        $display("Error at %0t ns: rx_ready high with a packet waiting", $time);
      end
      parked = 0;
      if (rx_byte_valid && rx_ready)
      begin
        shift = {shift[`ERX_PW-9:0], rx_byte};
        nbytes++;
      end
      // Burst flag taken before this edge updates it
      if (nbytes == `ERX_BYTES)
      begin
        nbytes = 0;
        parked = 1;
        predict(erx_packet_t'(shift), cont);
        if (rx_frame)
          cont = 1;
      end
      if (!rx_frame)
        cont = 0;
    end
  end

endmodule

//--- tests/erx_tb.sv
/* Receive link testbench
   Random framed packets, bursts, test phases and output back-pressure */
`include "erx_macros.svh"

module erx_tb import erx_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        reset;
  logic        test_mode;
  logic [7:0]  rx_byte;
  logic        rx_frame;
  logic        rx_byte_valid;
  logic        rx_ready;
  logic        req_valid;
  logic        req_ready;
  erx_packet_t req_packet;
  logic        rr_valid;
  logic        rr_ready;
  erx_packet_t rr_packet;
  logic [15:0] test_count;
  logic [31:0] test_signature;
  logic [31:0] seed;
  logic [31:0] rdy_seed;
  bit          stall_on;

  erx_top UUT (.*);
  erx_checker chk (.*);

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'h0019660d + 32'h3c6ef35f;
  endfunction

  initial
  begin
    clk = 0;
    forever #4 clk = ~clk;
  end

  // 400 packets at 40 cycles each
  initial
  begin
    repeat (400 * 40) @(posedge clk);
    $display("Timeout: the DUT stopped moving packets");
    $display("test failed");
    $finish;
  end

  // Random back-pressure on both ports, starting at reset release
  initial
  begin
    @(negedge reset);
    forever
    begin
      @(negedge clk);
      rdy_seed = lcg(rdy_seed);
      req_ready = !stall_on || rdy_seed[25:24] != 0;
      rr_ready  = !stall_on || rdy_seed[29:28] != 0;
    end
  end

  // One packet, byte 0 first; keep holds the frame for a burst
  task automatic send_packet(input erx_packet_t p, input bit keep);
    logic [`ERX_PW-1:0] bits;
    int gap;
    bits = p;
    if (!keep)
    begin
      @(negedge clk);
      rx_byte_valid = 0;
      rx_frame = 0;
    end
    for (int i = 0; i < `ERX_BYTES; i++)
    begin
      seed = lcg(seed);
      gap = seed[27:26];
      repeat (gap)
      begin
        @(negedge clk);
        rx_byte_valid = 0;
        rx_frame = 1;
      end
      @(negedge clk);
      // Sender must obey rx_ready
      while (!rx_ready)
      begin
        rx_byte_valid = 0;
        rx_frame = 1;
        @(negedge clk);
      end
      rx_byte = bits[`ERX_PW-1-8*i -: 8];
      rx_frame = 1;
      rx_byte_valid = 1;
    end
  endtask

  // Idle means nothing parked and no output pending for a few cycles
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 4)
    begin
      @(negedge clk);
      rx_byte_valid = 0;
      rx_frame = 0;
      if (rx_ready && !req_valid && !rr_valid)
        quiet++;
      else
        quiet = 0;
    end
  endtask

  initial
  begin
    erx_packet_t p;
    int          run_left;
    int          total;
    bit          burst;
    reset = 1;
    test_mode = 0;
    rx_byte = '0;
    rx_frame = 0;
    rx_byte_valid = 0;
    req_ready = 1;
    rr_ready = 1;
    stall_on = 0;
    seed = 32'hf2d3;
    rdy_seed = lcg(32'hf2d3 ^ 32'h5a5a5a5a);
    repeat (8) @(negedge clk);
    reset = 0;
    for (int phase = 0; phase < 8; phase++)
    begin
      wait_idle();
      seed = lcg(seed);
      // Test mode only between packets, with the DUT idle
      test_mode = (phase == 3 || phase == 6) ? 1'b1 : (phase == 0 ? 1'b0 : seed[30]);
      stall_on = (phase % 2 == 1) || seed[29];
      run_left = 0;
      for (int k = 0; k < 50; k++)
      begin
        seed = lcg(seed);
        burst = run_left > 0;
        if (burst)
          run_left--;
        else if (seed[31:30] == 0)
          run_left = seed[29:28] + 1;
        seed = lcg(seed);
        p.srcaddr = seed;
        seed = lcg(seed);
        p.data = seed;
        seed = lcg(seed);
        p.ctrl = seed[7:0];
        p.dstaddr.raw = lcg(seed);
        // Exact response address and near misses
        case (seed[31:29])
          3'd0, 3'd1: p.dstaddr.raw[31:16] = {`ERX_ID, `ERX_GROUP_RR};
          3'd2:       p.dstaddr.raw[31:16] = {`ERX_ID + 12'd1, `ERX_GROUP_RR};
          3'd3:       p.dstaddr.raw[31:16] = {`ERX_ID, `ERX_GROUP_RR - 4'd1};
          default:    ;
        endcase
        send_packet(p, burst);
      end
      wait_idle();
      chk.check_idle();
    end
    total = chk.value_errors + chk.other_errors;
    $display("Errors: %0d wrong values, %0d other failures, %0d total",
             chk.value_errors, chk.other_errors, total);
    if (total == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/erx_pkg.sv
hdl/erx_pkt_if.sv
hdl/erx_deframer.sv
hdl/erx_protocol.sv
hdl/erx_dispatch.sv
hdl/erx_test_sink.sv
hdl/erx_top.sv
tests/erx_checker.sv
tests/erx_tb.sv
